//--- logic/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wiscPkg::wordT  a,
    input  wiscPkg::wordT  b,
    input  wiscPkg::aluOpT aluOp,
    input  logic           invA,
    input  logic           invB,
    input  logic           cin,
    output wiscPkg::wordT  aluResult,
    output logic           aluZero,
    output logic           aluNeg
);
    import wiscPkg::*;

    wordT        opA;
    wordT        opB;
    wordT        sum;
    logic        carryOut;
    logic        overflow;
    logic        less;
    logic [3:0]  shAmt;
    logic [31:0] rotLeft;
    logic [31:0] rotRight;
    wordT        reversed;

    assign opA = invA ? ~a : a;
    assign opB = invB ? ~b : b;
    assign {carryOut, sum} = 17'(opA) + 17'(opB) + 17'(cin);

    // signed compare from the a minus b sum
    assign overflow = (opA[15] == opB[15]) && (sum[15] != opA[15]);
    assign less     = sum[15] ^ overflow;

    // rotates from a doubled word
    assign shAmt    = b[3:0];
    assign rotLeft  = {a, a} << shAmt;
    assign rotRight = {a, a} >> shAmt;

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            reversed[i] = a[15-i];
        end
    end

    always_comb begin
        case (aluOp)
            aluRol:    aluResult = rotLeft[31:16];
            aluSll:    aluResult = a << shAmt;
            aluRor:    aluResult = rotRight[15:0];
            aluSrl:    aluResult = a >> shAmt;
            aluAnd:    aluResult = opA & opB;
            aluXor:    aluResult = opA ^ opB;
            aluSeq:    aluResult = {15'd0, sum == 16'd0};
            aluSlt:    aluResult = {15'd0, less};
            aluSco:    aluResult = {15'd0, carryOut};
            aluSle:    aluResult = {15'd0, less | (sum == 16'd0)};
            // j and jal, the next-pc unit builds the target
            aluPassPc: aluResult = a;
            // operand a arrives already shifted by 8
            aluSlbi:   aluResult = opA | opB;
            aluBtr:    aluResult = reversed;
            default:   aluResult = sum;
        endcase
    end

    // branch flags look at rs directly
    assign aluZero = (a == 16'd0);
    assign aluNeg  = a[15];

endmodule

`default_nettype wire

//--- logic/control.sv
`timescale 1ns/1ns
`default_nettype none

module control (
    input  wiscPkg::opcodeT opcode,
    input  logic [1:0]      func,
    output logic            err,
    output logic            halt,
    output logic            zeroExt,
    output logic            immSrc,
    output logic            aluJump,
    output logic            regWrite,
    output logic            memRead,
    output logic            memWrite,
    output logic            invA,
    output logic            invB,
    output logic            cin,
    output logic            beq,
    output logic            bne,
    output logic            blt,
    output logic            bge,
    output logic [1:0]      regDst,
    output logic [1:0]      memToReg,
    output logic [1:0]      aluSrc1,
    output logic [1:0]      aluSrc2,
    output wiscPkg::aluOpT  aluOp
);
    import wiscPkg::*;

    always_comb begin
        // most instructions write a register from the alu
        err      = 1'b0;
        halt     = 1'b0;
        zeroExt  = 1'b0;
        immSrc   = 1'b0;
        aluJump  = 1'b0;
        regWrite = 1'b1;
        memRead  = 1'b0;
        memWrite = 1'b0;
        invA     = 1'b0;
        invB     = 1'b0;
        cin      = 1'b0;
        beq      = 1'b0;
        bne      = 1'b0;
        blt      = 1'b0;
        bge      = 1'b0;
        regDst   = 2'b00;
        memToReg = 2'b10;
        aluSrc1  = 2'b00;
        aluSrc2  = 2'b00;
        aluOp    = aluAdd;

        case (opcode)
            opHalt: begin
                halt     = 1'b1;
                regWrite = 1'b0;
            end
            opNop: regWrite = 1'b0;
            // immediate arithmetic, subtract is imm minus rs
            opAddi: aluSrc2 = 2'b01;
            opSubi: begin
                aluSrc2 = 2'b01;
                invA    = 1'b1;
                cin     = 1'b1;
            end
            opXori: begin
                aluSrc2 = 2'b01;
                zeroExt = 1'b1;
                aluOp   = aluXor;
            end
            opAndni: begin
                aluSrc2 = 2'b01;
                zeroExt = 1'b1;
                invB    = 1'b1;
                aluOp   = aluAnd;
            end
            // shift immediates, low opcode bits pick the shift
            opRoli, opSlli, opRori, opSrli: begin
                aluSrc2 = 2'b01;
                zeroExt = 1'b1;
                aluOp   = aluOpT'({2'b00, opcode[1:0]});
            end
            opSt: begin
                aluSrc2  = 2'b01;
                regWrite = 1'b0;
                memWrite = 1'b1;
            end
            opLd: begin
                aluSrc2  = 2'b01;
                memToReg = 2'b01;
                memRead  = 1'b1;
            end
            // store, then rs takes the address
            opStu: begin
                aluSrc2  = 2'b01;
                regDst   = 2'b01;
                memWrite = 1'b1;
            end
            opBtr: begin
                regDst = 2'b10;
                aluOp  = aluBtr;
            end
            opArithR: begin
                regDst = 2'b10;
                case (func)
                    2'b00: aluOp = aluAdd;
                    2'b01: begin
                        invA = 1'b1;
                        cin  = 1'b1;
                    end
                    2'b10: aluOp = aluXor;
                    default: begin
                        invB  = 1'b1;
                        aluOp = aluAnd;
                    end
                endcase
            end
            opShiftR: begin
                regDst = 2'b10;
                aluOp  = aluOpT'({2'b00, func});
            end
            // compares run as rs minus rt
            opSeq, opSlt, opSle: begin
                regDst = 2'b10;
                invB   = 1'b1;
                cin    = 1'b1;
                aluOp  = (opcode == opSeq) ? aluSeq : (opcode == opSlt) ? aluSlt : aluSle;
            end
            opSco: begin
                regDst = 2'b10;
                aluOp  = aluSco;
            end
            opBeqz, opBnez, opBltz, opBgez: begin
                aluSrc2  = 2'b11;
                regWrite = 1'b0;
                beq      = (opcode == opBeqz);
                bne      = (opcode == opBnez);
                blt      = (opcode == opBltz);
                bge      = (opcode == opBgez);
            end
            opLbi: begin
                regDst  = 2'b01;
                aluSrc1 = 2'b01;
                aluSrc2 = 2'b10;
            end
            opSlbi: begin
                regDst  = 2'b01;
                aluSrc1 = 2'b10;
                aluSrc2 = 2'b10;
                zeroExt = 1'b1;
                aluOp   = aluSlbi;
            end
            opJ: begin
                regWrite = 1'b0;
                immSrc   = 1'b1;
                aluOp    = aluPassPc;
            end
            opJr: begin
                aluSrc2  = 2'b10;
                regWrite = 1'b0;
                aluJump  = 1'b1;
            end
            // link goes to r7
            opJal: begin
                regDst   = 2'b11;
                memToReg = 2'b00;
                immSrc   = 1'b1;
                aluOp    = aluPassPc;
            end
            opJalr: begin
                regDst   = 2'b11;
                memToReg = 2'b00;
                aluSrc2  = 2'b10;
                aluJump  = 1'b1;
            end
            default: begin
                err      = 1'b1;
                regWrite = 1'b0;
                memWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/dataMem.sv
`timescale 1ns/1ns
`default_nettype none

module dataMem #(
    parameter int memWords = 256
) (
    input  logic          clk,
    input  wiscPkg::wordT addr,
    input  wiscPkg::wordT wrData,
    input  logic          memWrite,
    output wiscPkg::wordT rdData
);
    import wiscPkg::*;

    localparam int idxBits = $clog2(memWords);

    wordT               mem [memWords] = '{default: '0};
    logic [idxBits-1:0] idx;

    // word index, bit 0 is the byte within the word
    assign idx = addr[idxBits:1];

    always_ff @(posedge clk) begin
        if (memWrite) begin
            mem[idx] <= wrData;
        end
    end

    assign rdData = mem[idx];

endmodule

`default_nettype wire

//--- logic/nextPc.sv
`timescale 1ns/1ns
`default_nettype none

module nextPc (
    input  logic          clk,
    input  logic          rstN,
    input  logic          stop,
    input  logic          beq,
    input  logic          bne,
    input  logic          blt,
    input  logic          bge,
    input  logic          aluZero,
    input  logic          aluNeg,
    input  logic          immSrc,
    input  logic          aluJump,
    input  wiscPkg::wordT imm8Ext,
    input  wiscPkg::wordT imm11Ext,
    input  wiscPkg::wordT aluResult,
    output wiscPkg::wordT pc,
    output wiscPkg::wordT pcPlus2
);
    import wiscPkg::*;

    wordT pcNext;
    logic taken;

    assign pcPlus2 = pc + 16'd2;
    assign taken   = (beq & aluZero) | (bne & ~aluZero) |
                     (blt & aluNeg) | (bge & ~aluNeg);

    always_comb begin
        if (stop) begin
            pcNext = pc;
        end else if (aluJump) begin
            pcNext = aluResult;
        end else if (immSrc) begin
            pcNext = pcPlus2 + imm11Ext;
        end else if (taken) begin
            pcNext = pcPlus2 + imm8Ext;
        end else begin
            pcNext = pcPlus2;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

//--- logic/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  logic            clk,
    input  logic            rstN,
    input  wiscPkg::regIdxT rdAddr1,
    input  wiscPkg::regIdxT rdAddr2,
    input  wiscPkg::regIdxT wrAddr,
    input  wiscPkg::wordT   wrData,
    input  logic            wrEn,
    output wiscPkg::wordT   rdData1,
    output wiscPkg::wordT   rdData2
);
    import wiscPkg::*;

    wordT regs [8];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // no bypass, same-cycle read sees the old value
    assign rdData1 = regs[rdAddr1];
    assign rdData2 = regs[rdAddr2];

endmodule

`default_nettype wire

//--- logic/wiscCore.sv
`timescale 1ns/1ns
`default_nettype none

module wiscCore #(
    parameter int memWords = 256
) (
    input  logic            clk,
    input  logic            rstN,
    input  wiscPkg::wordT   instr,
    output wiscPkg::wordT   pc,
    output logic            wbEn,
    output wiscPkg::regIdxT wbReg,
    output wiscPkg::wordT   wbData,
    output logic            halt,
    output logic            err
);
    import wiscPkg::*;

    opcodeT     opcode;
    logic [1:0] func;
    logic       zeroExt;
    logic       immSrc;
    logic       aluJump;
    logic       regWrite;
    logic       memRead;
    logic       memWrite;
    logic       invA;
    logic       invB;
    logic       cin;
    logic       beq;
    logic       bne;
    logic       blt;
    logic       bge;
    logic [1:0] regDst;
    logic [1:0] memToReg;
    logic [1:0] aluSrc1;
    logic [1:0] aluSrc2;
    aluOpT      aluOp;
    wordT       imm5Ext;
    wordT       imm8Ext;
    wordT       imm11Ext;
    wordT       rdData1;
    wordT       rdData2;
    wordT       aluA;
    wordT       aluB;
    wordT       aluResult;
    logic       aluZero;
    logic       aluNeg;
    wordT       memRdData;
    wordT       memData;
    wordT       pcPlus2;
    logic       stop;
    logic       memWe;

    assign opcode = instr[15:11];
    assign func   = instr[1:0];

    control i_control (
        .opcode(opcode), .func(func), .err(err), .halt(halt),
        .zeroExt(zeroExt), .immSrc(immSrc), .aluJump(aluJump),
        .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
        .invA(invA), .invB(invB), .cin(cin),
        .beq(beq), .bne(bne), .blt(blt), .bge(bge),
        .regDst(regDst), .memToReg(memToReg),
        .aluSrc1(aluSrc1), .aluSrc2(aluSrc2), .aluOp(aluOp)
    );

    // immediates, zeroExt picks zero or sign fill
    assign imm5Ext  = {{11{~zeroExt & instr[4]}}, instr[4:0]};
    assign imm8Ext  = {{8{~zeroExt & instr[7]}}, instr[7:0]};
    assign imm11Ext = {{5{~zeroExt & instr[10]}}, instr[10:0]};

    // halted or illegal, nothing gets written
    assign stop  = halt | err;
    assign wbEn  = regWrite & ~stop;
    assign memWe = memWrite & ~stop;

    regFile i_regFile (
        .clk(clk), .rstN(rstN),
        .rdAddr1(instr[10:8]), .rdAddr2(instr[7:5]),
        .wrAddr(wbReg), .wrData(wbData), .wrEn(wbEn),
        .rdData1(rdData1), .rdData2(rdData2)
    );

    always_comb begin
        case (aluSrc1)
            2'b00:   aluA = rdData1;
            2'b10:   aluA = rdData1 << 8;
            default: aluA = '0;
        endcase
        case (aluSrc2)
            2'b00:   aluB = rdData2;
            2'b01:   aluB = imm5Ext;
            2'b10:   aluB = imm8Ext;
            default: aluB = '0;
        endcase
    end

    alu i_alu (
        .a(aluA), .b(aluB), .aluOp(aluOp),
        .invA(invA), .invB(invB), .cin(cin),
        .aluResult(aluResult), .aluZero(aluZero), .aluNeg(aluNeg)
    );

    dataMem #(
        .memWords(memWords)
    ) i_dataMem (
        .clk(clk), .addr(aluResult), .wrData(rdData2),
        .memWrite(memWe), .rdData(memRdData)
    );

    // load data only shows on loads
    assign memData = memRead ? memRdData : '0;

    always_comb begin
        case (memToReg)
            2'b00:   wbData = pcPlus2;
            2'b01:   wbData = memData;
            default: wbData = aluResult;
        endcase
        case (regDst)
            2'b00:   wbReg = instr[7:5];
            2'b01:   wbReg = instr[10:8];
            2'b10:   wbReg = instr[4:2];
            default: wbReg = 3'd7;
        endcase
    end

    nextPc i_nextPc (
        .clk(clk), .rstN(rstN), .stop(stop),
        .beq(beq), .bne(bne), .blt(blt), .bge(bge),
        .aluZero(aluZero), .aluNeg(aluNeg),
        .immSrc(immSrc), .aluJump(aluJump),
        .imm8Ext(imm8Ext), .imm11Ext(imm11Ext), .aluResult(aluResult),
        .pc(pc), .pcPlus2(pcPlus2)
    );

endmodule

`default_nettype wire

//--- logic/wiscPkg.sv
package wiscPkg;

    // datapath word, register number, alu select, opcode
    typedef logic [15:0] wordT;
    typedef logic [2:0]  regIdxT;
    typedef logic [3:0]  aluOpT;
    typedef logic [4:0]  opcodeT;

    // alu operations, low four match the shift func field
    localparam aluOpT aluRol    = 4'b0000;
    localparam aluOpT aluSll    = 4'b0001;
    localparam aluOpT aluRor    = 4'b0010;
    localparam aluOpT aluSrl    = 4'b0011;
    localparam aluOpT aluAdd    = 4'b0100;
    localparam aluOpT aluAnd    = 4'b0101;
    localparam aluOpT aluXor    = 4'b0111;
    localparam aluOpT aluSeq    = 4'b1001;
    localparam aluOpT aluSlt    = 4'b1010;
    localparam aluOpT aluSco    = 4'b1011;
    localparam aluOpT aluSle    = 4'b1100;
    localparam aluOpT aluPassPc = 4'b1101;
    localparam aluOpT aluSlbi   = 4'b1110;
    localparam aluOpT aluBtr    = 4'b1111;

    // opcodes
    localparam opcodeT opHalt   = 5'b00000;
    localparam opcodeT opNop    = 5'b00001;
    localparam opcodeT opJ      = 5'b00100;
    localparam opcodeT opJr     = 5'b00101;
    localparam opcodeT opJal    = 5'b00110;
    localparam opcodeT opJalr   = 5'b00111;
    localparam opcodeT opAddi   = 5'b01000;
    localparam opcodeT opSubi   = 5'b01001;
    localparam opcodeT opXori   = 5'b01010;
    localparam opcodeT opAndni  = 5'b01011;
    localparam opcodeT opBeqz   = 5'b01100;
    localparam opcodeT opBnez   = 5'b01101;
    localparam opcodeT opBltz   = 5'b01110;
    localparam opcodeT opBgez   = 5'b01111;
    localparam opcodeT opSt     = 5'b10000;
    localparam opcodeT opLd     = 5'b10001;
    localparam opcodeT opSlbi   = 5'b10010;
    localparam opcodeT opStu    = 5'b10011;
    localparam opcodeT opRoli   = 5'b10100;
    localparam opcodeT opSlli   = 5'b10101;
    localparam opcodeT opRori   = 5'b10110;
    localparam opcodeT opSrli   = 5'b10111;
    localparam opcodeT opLbi    = 5'b11000;
    localparam opcodeT opBtr    = 5'b11001;
    localparam opcodeT opShiftR = 5'b11010;
    localparam opcodeT opArithR = 5'b11011;
    localparam opcodeT opSeq    = 5'b11100;
    localparam opcodeT opSlt    = 5'b11101;
    localparam opcodeT opSle    = 5'b11110;
    localparam opcodeT opSco    = 5'b11111;

endpackage

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --top-module wiscCoreTb -f wiscCore.f

out="$(./obj_dir/VwiscCoreTb)" || true
echo "$out"

# pass only when the testbench printed its pass line
echo "$out" | grep -qx "No errors"

//--- verif/wiscCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

module wiscCoreTb;
    import wiscPkg::*;

    localparam int   maxSteps    = 256;
    localparam int   resetCycles = 4;
    localparam int   freezeSteps = 3;
    // lands only when a branch or jump goes wrong
    localparam wordT skipWord    = {opLbi, 3'd7, 8'ha5};

    logic   clk;
    logic   rstN;
    wordT   instr;
    wordT   pc;
    logic   wbEn;
    regIdxT wbReg;
    wordT   wbData;
    logic   halt;
    logic   err;

    // instruction store, one program per run
    wordT   prog [2][128] = '{default: '0};
    int     progLen [2];
    logic   curRun;
    logic   runSel;

    // expected values, one entry per executed cycle of both runs
    wordT   expPc [maxSteps];
    logic   expWbEn [maxSteps];
    regIdxT expWbReg [maxSteps];
    wordT   expWbData [maxSteps];
    logic   expHalt [maxSteps];
    logic   expErr [maxSteps];
    int     stepCount;
    int     run1Len;

    // reference model state
    wordT   modelRegs [8];
    wordT   modelMem [256] = '{default: '0};
    wordT   modelPc;

    logic [31:0] rngState;
    int          errorCount;
    int          checkCount;
    int          cycleCount;
    int          cycleLimit;

    wiscCore #(
        .memWords(256)
    ) i_wiscCore (
        .clk(clk), .rstN(rstN), .instr(instr), .pc(pc),
        .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
        .halt(halt), .err(err)
    );

    // instruction memory answers in the same cycle
    assign instr = prog[runSel][pc[7:1]];

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout, the run did not end within %0d cycles", cycleLimit);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic wordT randomWord();
        rngState = xorshift32(rngState);
        return rngState[15:0];
    endfunction

    function automatic wordT rotateLeft(input wordT v, input logic [3:0] n);
        return (v << n) | (v >> (5'd16 - n));
    endfunction

    function automatic wordT rotateRight(input wordT v, input logic [3:0] n);
        return (v >> n) | (v << (5'd16 - n));
    endfunction

    function automatic wordT bitReverse(input wordT v);
        wordT r;
        for (int i = 0; i < 16; i++) begin
            r[i] = v[15-i];
        end
        return r;
    endfunction

    task automatic emit(input wordT ins);
        prog[curRun][7'(progLen[curRun])] = ins;
        progLen[curRun]++;
    endtask

    task automatic loadWord(input regIdxT r, input wordT v);
        emit({opLbi, r, v[15:8]});
        emit({opSlbi, r, v[7:0]});
    endtask

    // one taken and one falling-through branch of a kind
    task automatic emitBranches(input opcodeT op, input regIdxT takenReg,
                                input regIdxT fallReg);
        emit({op, takenReg, 8'd2});
        emit(skipWord);
        emit({op, fallReg, 8'd2});
        emit({opLbi, 3'd7, 8'h5a});
    endtask

    task automatic buildMainProgram();
        wordT r;
        int   p;
        curRun = 1'b0;
        loadWord(3'd1, randomWord());
        loadWord(3'd2, randomWord());
        loadWord(3'd3, randomWord());
        emit({opNop, 11'd0});
        r = randomWord();
        emit({opAddi, 3'd1, 3'd4, r[4:0]});
        emit({opSubi, 3'd2, 3'd5, r[9:5]});
        emit({opXori, 3'd3, 3'd6, r[14:10]});
        r = randomWord();
        emit({opAndni, 3'd2, 3'd4, r[4:0]});
        emit({opArithR, 3'd1, 3'd2, 3'd4, 2'b00});
        emit({opArithR, 3'd1, 3'd2, 3'd5, 2'b01});
        emit({opArithR, 3'd1, 3'd3, 3'd6, 2'b10});
        emit({opArithR, 3'd2, 3'd3, 3'd4, 2'b11});
        emit({opRoli, 3'd3, 3'd4, r[9:5]});
        emit({opSlli, 3'd3, 3'd5, r[14:10]});
        r = randomWord();
        emit({opRori, 3'd1, 3'd6, r[4:0]});
        emit({opSrli, 3'd1, 3'd4, r[9:5]});
        // register shifts, amount taken from r2
        for (int f = 0; f < 4; f++) begin
            emit({opShiftR, 3'd3, 3'd2, 3'd5, 2'(f)});
        end
        emit({opBtr, 3'd1, 3'd0, 3'd6, 2'b00});
        emit({opSeq, 3'd1, 3'd2, 3'd4, 2'b00});
        emit({opSeq, 3'd3, 3'd3, 3'd4, 2'b00});
        emit({opSlt, 3'd1, 3'd2, 3'd5, 2'b00});
        emit({opSlt, 3'd2, 3'd1, 3'd5, 2'b00});
        emit({opSle, 3'd1, 3'd1, 3'd6, 2'b00});
        emit({opSle, 3'd2, 3'd3, 3'd6, 2'b00});
        emit({opSco, 3'd1, 3'd2, 3'd4, 2'b00});
        emit({opSco, 3'd3, 3'd3, 3'd4, 2'b00});
        // store and load back, then stu moves the base
        loadWord(3'd6, randomWord());
        r = randomWord();
        emit({opSt, 3'd6, 3'd1, r[4:0]});
        emit({opLd, 3'd6, 3'd4, r[4:0]});
        emit({opStu, 3'd6, 3'd2, r[9:5]});
        emit({opLd, 3'd6, 3'd5, 5'd0});
        // r0 is zero, r2 positive, r3 negative
        emit({opLbi, 3'd2, 8'd5});
        emit({opLbi, 3'd3, 8'hfd});
        emitBranches(opBeqz, 3'd0, 3'd2);
        emitBranches(opBnez, 3'd2, 3'd0);
        emitBranches(opBltz, 3'd3, 3'd2);
        emitBranches(opBgez, 3'd2, 3'd3);
        emit({opJ, 11'd2});
        emit(skipWord);
        emit({opJal, 11'd2});
        emit(skipWord);
        // register jumps land two slots past themselves
        p = progLen[0];
        loadWord(3'd5, 16'(2 * (p + 4)));
        emit({opJr, 3'd5, 8'd0});
        emit(skipWord);
        p = progLen[0];
        loadWord(3'd6, 16'(2 * (p + 3)));
        emit({opJalr, 3'd6, 8'd2});
        emit(skipWord);
        emit({opNop, 11'd0});
        emit({opHalt, 11'd0});
    endtask

    task automatic buildErrorProgram();
        wordT r;
        curRun = 1'b1;
        r = randomWord();
        emit({opLbi, 3'd1, r[7:0]});
        emit({opAddi, 3'd1, 3'd2, r[12:8]});
        // opcode 00010 has no instruction
        emit({5'b00010, r[10:0]});
        emit({opAddi, 3'd2, 3'd3, 5'd1});
    endtask

    // executes one instruction by the ISA rules and records the cycle
    task automatic modelStep(input wordT ins, output logic stopped);
        opcodeT      op;
        regIdxT      rs;
        regIdxT      dst;
        wordT        a;
        wordT        b;
        wordT        s5;
        wordT        z5;
        wordT        s8;
        wordT        s11;
        wordT        addr;
        wordT        pc2;
        wordT        npc;
        wordT        res;
        logic        wr;
        logic [16:0] wide;
        logic [7:0]  idx;
        op      = ins[15:11];
        rs      = ins[10:8];
        a       = modelRegs[rs];
        b       = modelRegs[ins[7:5]];
        s5      = {{11{ins[4]}}, ins[4:0]};
        z5      = {11'd0, ins[4:0]};
        s8      = {{8{ins[7]}}, ins[7:0]};
        s11     = {{5{ins[10]}}, ins[10:0]};
        addr    = a + s5;
        pc2     = modelPc + 16'd2;
        npc     = pc2;
        res     = '0;
        wr      = 1'b1;
        stopped = 1'b0;
        idx     = 8'(stepCount);
        // r-format opcodes all sit above lbi
        dst     = (op > opLbi) ? ins[4:2] : ins[7:5];
        expPc[idx]   = modelPc;
        expHalt[idx] = 1'b0;
        expErr[idx]  = 1'b0;
        case (op)
            opHalt: begin
                wr           = 1'b0;
                npc          = modelPc;
                stopped      = 1'b1;
                expHalt[idx] = 1'b1;
            end
            opNop:   wr = 1'b0;
            opAddi:  res = a + s5;
            opSubi:  res = s5 - a;
            opXori:  res = a ^ z5;
            opAndni: res = a & ~z5;
            opRoli:  res = rotateLeft(a, ins[3:0]);
            opSlli:  res = a << ins[3:0];
            opRori:  res = rotateRight(a, ins[3:0]);
            opSrli:  res = a >> ins[3:0];
            opSt: begin
                wr                   = 1'b0;
                modelMem[addr[8:1]] = b;
            end
            opLd: res = modelMem[addr[8:1]];
            opStu: begin
                modelMem[addr[8:1]] = b;
                dst                  = rs;
                res                  = addr;
            end
            opBtr: res = bitReverse(a);
            opArithR: begin
                case (ins[1:0])
                    2'b00:   res = a + b;
                    2'b01:   res = b - a;
                    2'b10:   res = a ^ b;
                    default: res = a & ~b;
                endcase
            end
            opShiftR: begin
                case (ins[1:0])
                    2'b00:   res = rotateLeft(a, b[3:0]);
                    2'b01:   res = a << b[3:0];
                    2'b10:   res = rotateRight(a, b[3:0]);
                    default: res = a >> b[3:0];
                endcase
            end
            opSeq: res = {15'd0, a == b};
            opSlt: res = {15'd0, $signed(a) < $signed(b)};
            opSle: res = {15'd0, $signed(a) <= $signed(b)};
            opSco: begin
                wide = {1'b0, a} + {1'b0, b};
                res  = {15'd0, wide[16]};
            end
            opBeqz: begin
                wr = 1'b0;
                if (a == 16'd0) npc = pc2 + s8;
            end
            opBnez: begin
                wr = 1'b0;
                if (a != 16'd0) npc = pc2 + s8;
            end
            opBltz: begin
                wr = 1'b0;
                if (a[15]) npc = pc2 + s8;
            end
            opBgez: begin
                wr = 1'b0;
                if (!a[15]) npc = pc2 + s8;
            end
            opLbi: begin
                dst = rs;
                res = s8;
            end
            opSlbi: begin
                dst = rs;
                res = {a[7:0], ins[7:0]};
            end
            opJ: begin
                wr  = 1'b0;
                npc = pc2 + s11;
            end
            opJr: begin
                wr  = 1'b0;
                npc = a + s8;
            end
            opJal: begin
                dst = 3'd7;
                res = pc2;
                npc = pc2 + s11;
            end
            opJalr: begin
                dst = 3'd7;
                res = pc2;
                npc = a + s8;
            end
            default: begin
                wr          = 1'b0;
                npc         = modelPc;
                stopped     = 1'b1;
                expErr[idx] = 1'b1;
            end
        endcase
        expWbEn[idx]   = wr;
        expWbReg[idx]  = dst;
        expWbData[idx] = res;
        if (wr) modelRegs[dst] = res;
        modelPc = npc;
        stepCount++;
    endtask

    // runs a program from reset until it stops, plus a few frozen cycles
    task automatic modelRun(input logic run);
        logic stopped;
        int   frozen;
        modelRegs = '{default: '0};
        modelPc   = '0;
        frozen    = 0;
        while (frozen <= freezeSteps && stepCount < maxSteps) begin
            modelStep(prog[run][modelPc[7:1]], stopped);
            if (stopped) frozen++;
        end
    endtask

    task automatic compareField(input string name, input wordT expected, input wordT actual);
        checkCount++;
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkStep(input int k);
        logic [7:0] idx;
        idx = 8'(k);
        compareField("pc", expPc[idx], pc);
        compareField("halt", 16'(expHalt[idx]), 16'(halt));
        compareField("err", 16'(expErr[idx]), 16'(err));
        compareField("wbEn", 16'(expWbEn[idx]), 16'(wbEn));
        if (expWbEn[idx]) begin
            compareField("wbReg", 16'(expWbReg[idx]), 16'(wbReg));
            compareField("wbData", expWbData[idx], wbData);
        end
    endtask

    task automatic releaseReset();
        repeat (resetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
    endtask

    initial begin
        rstN       = 1'b0;
        runSel     = 1'b0;
        rngState   = 32'h2593_e65a;
        errorCount = 0;
        checkCount = 0;
        cycleCount = 0;
        stepCount  = 0;
        progLen[0] = 0;
        progLen[1] = 0;
        buildMainProgram();
        buildErrorProgram();
        modelRun(1'b0);
        run1Len = stepCount;
        modelRun(1'b1);
        cycleLimit = stepCount + 2 * (resetCycles + 1) + 20;

        releaseReset();
        for (int k = 0; k < stepCount; k++) begin
            if (k == run1Len) begin
                // second program starts from a fresh reset
                @(posedge clk);
                #1;
                rstN   = 1'b0;
                runSel = 1'b1;
                releaseReset();
            end
            // outputs are settled half a cycle after the edge
            @(negedge clk);
            checkStep(k);
        end

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/wiscCore_props.sv
`timescale 1ns/1ns
`default_nettype none

module wiscCoreProps (
    input logic          clk,
    input logic          rstN,
    input wiscPkg::wordT pc,
    input logic          halt,
    input logic          err
);

    // once stopped, the core stays frozen until reset
    stopHolds: assert property (@(posedge clk) disable iff (!rstN)
        (halt || err) |=> $stable(pc) && (halt || err))
        else $error("core left its stopped state before reset");

    pcAdvances: assert property (@(posedge clk) disable iff (!rstN)
        !(halt || err) |=> pc != $past(pc))
        else $error("pc stayed put after an active cycle");

    pcEven: assert property (@(posedge clk) disable iff (!rstN)
        pc[0] == 1'b0)
        else $error("pc is odd");

endmodule

bind wiscCore wiscCoreProps i_wiscCoreProps (
    .clk(clk), .rstN(rstN), .pc(pc), .halt(halt), .err(err)
);

`default_nettype wire

//--- wiscCore.f
logic/wiscPkg.sv
logic/control.sv
logic/alu.sv
logic/regFile.sv
logic/nextPc.sv
logic/dataMem.sv
logic/wiscCore.sv
verif/wiscCore_props.sv
verif/wiscCoreTb.sv
